// File: common/ctrl_defs.svh
// rv32 base encoding assumed, rs3 only exists in r4-type instructions and aliases funct7 bits
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// architectural register index
`define REG_ADDR_W 5

// instruction word
`define XLEN 32

//////////////////////////////////////////////////
// source and destination field positions
//////////////////////////////////////////////////

// rs1 sits at bits 19..15
`define RS1_LSB 15

// rs2 sits at bits 24..20
`define RS2_LSB 20

// rd sits at bits 11..7, opcode fills everything below it
`define RD_LSB 7

// rs3 sits at bits 31..27 in the r4 view
`define RS3_LSB 27

`endif

// File: common/ctrl_pkg.sv
// sequencing types only, pc select codes must match the fetch stage mux order
package ctrl_pkg;

  //////////////////////////////////////////////////
  // controller state
  //////////////////////////////////////////////////

  // reset value is RESET, encoding order follows the boot path
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    BRANCH_DELAY,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  // fetch stage pc source
  // codes 3'b001, 3'b110 and 3'b111 are left free in the fetch mux
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_sel_e;

  // jump classification coming from the decoder
  typedef enum logic [1:0] {
    NONE = 2'b00,
    JAL  = 2'b01,
    JALR = 2'b10,
    COND = 2'b11
  } jump_kind_e;

  //////////////////////////////////////////////////
  // redirect request
  //////////////////////////////////////////////////

  // jump_only marks a request that must wait out a jump-register stall
  typedef struct packed {
    logic    valid;
    pc_sel_e pc_sel;
    logic    jump_only;
  } redirect_req_t;

endpackage

// File: common/operand_pkg.sv
// operand side types, the instruction union assumes rv32 field layout from ctrl_defs.svh
`include "ctrl_defs.svh"

package operand_pkg;

  // r view, the usual register-register layout
  typedef struct packed {
    logic [`XLEN-`RS2_LSB-`REG_ADDR_W-1:0]   funct7;
    logic [`REG_ADDR_W-1:0]                  rs2;
    logic [`REG_ADDR_W-1:0]                  rs1;
    logic [`RS1_LSB-`RD_LSB-`REG_ADDR_W-1:0] funct3;
    logic [`REG_ADDR_W-1:0]                  rd;
    logic [`RD_LSB-1:0]                      opcode;
  } insn_r_t;

  // r4 view, funct7 splits into rs3 and a format field
  typedef struct packed {
    logic [`XLEN-`RS3_LSB-1:0]                rs3;
    logic [`RS3_LSB-`RS2_LSB-`REG_ADDR_W-1:0] fmt;
    logic [`REG_ADDR_W-1:0]                   rs2;
    logic [`REG_ADDR_W-1:0]                   rs1;
    logic [`RS1_LSB-`RD_LSB-`REG_ADDR_W-1:0]  funct3;
    logic [`REG_ADDR_W-1:0]                   rd;
    logic [`RD_LSB-1:0]                       opcode;
  } insn_r4_t;

  // one fetched word, two decodings of the same bits
  typedef union packed {
    insn_r_t  r;
    insn_r4_t r4;
  } insn_u;

  // operand mux select in the decode stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // register file write port seen from a later stage
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] waddr;
    logic                   we;
  } wr_port_t;

  // selects for operands a, b and c
  typedef struct packed {
    fwd_sel_e a;
    fwd_sel_e b;
    fwd_sel_e c;
  } fwd_sel_t;

endpackage

// File: ctrl/ctrl_fsm.sv
// single state register, all outputs are combinational and stage valids are level inputs
`timescale 1ns/100ps

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          fetch_enable_i,
  input  logic          exc_req_i,
  input  logic          eret_insn_i,
  input  logic          pipe_flush_i,
  input  jump_kind_e    jump_in_ex_i,
  input  jump_kind_e    jump_in_dec_i,
  input  logic          branch_decision_i,
  input  logic          if_valid_i,
  input  logic          id_valid_i,
  input  logic          ex_valid_i,
  input  logic          wb_valid_i,
  output redirect_req_t redirect_o,
  output logic          is_decoding_o,
  output logic          instr_req_o,
  output logic          core_busy_o,
  output logic          halt_if_o,
  output logic          halt_id_o,
  output logic          exc_ack_o,
  output logic          save_pc_if_o,
  output logic          save_pc_id_o
);

  ctrl_state_e   state_q;
  ctrl_state_e   state_d;
  redirect_req_t dec_req;
  logic          dec_is_jump;
  logic          branch_taken;

  // unconditional jump sitting in decode
  assign dec_is_jump  = (jump_in_dec_i == JAL) || (jump_in_dec_i == JALR);
  // conditional branch in ex that resolved taken
  assign branch_taken = (jump_in_ex_i == COND) && branch_decision_i;

  //////////////////////////////////////////////////
  // decode-side redirect candidate
  //////////////////////////////////////////////////

  // later assignments win, so eret beats exception beats jump
  always_comb
  begin
    dec_req = '{valid: 1'b0, pc_sel: PC_BOOT, jump_only: 1'b0};
    if (dec_is_jump)
    begin
      dec_req = '{valid: 1'b1, pc_sel: PC_JUMP, jump_only: 1'b1};
    end
    if (exc_req_i)
    begin
      dec_req = '{valid: 1'b1, pc_sel: PC_EXCEPTION, jump_only: 1'b0};
    end
    if (eret_insn_i)
    begin
      dec_req = '{valid: 1'b1, pc_sel: PC_ERET, jump_only: 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d       = state_q;
    redirect_o    = '{valid: 1'b0, pc_sel: PC_BOOT, jump_only: 1'b0};
    instr_req_o   = 1'b1;
    core_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_ack_o     = 1'b0;
    save_pc_if_o  = 1'b0;
    save_pc_id_o  = 1'b0;

    unique case (state_q)
      // idle out of reset, nothing fetched yet
      RESET:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into the fetch pc
      BOOT_SET:
      begin
        redirect_o = '{valid: 1'b1, pc_sel: PC_BOOT, jump_only: 1'b0};
        state_d    = FIRST_FETCH;
      end

      // woken by fetch enable or by a pending exception
      SLEEP:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach decode
      FIRST_FETCH:
      begin
        redirect_o   = dec_req;
        exc_ack_o    = exc_req_i;
        // jumps in decode already moved the if pc, keep the if copy
        save_pc_if_o = exc_req_i && dec_is_jump;
        save_pc_id_o = exc_req_i && !dec_is_jump;
        if (id_valid_i)
          state_d = DECODE;
      end

      DECODE:
      begin
        if (branch_taken)
        begin
          // decode instruction is on the wrong path
          redirect_o = '{valid: 1'b1, pc_sel: PC_BRANCH, jump_only: 1'b0};
          if (if_valid_i)
            state_d = DECODE;
          else
            state_d = BRANCH_DELAY;
        end
        else
        begin
          is_decoding_o = 1'b1;
          redirect_o    = dec_req;
          exc_ack_o     = exc_req_i;
          save_pc_if_o  = exc_req_i && dec_is_jump;
          save_pc_id_o  = exc_req_i && !dec_is_jump;

          // eret back into sleep when the core was only woken for it
          if (eret_insn_i && !fetch_enable_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end

          // wfi drains the pipe
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end
      end

      // branch target not yet fetched
      BRANCH_DELAY:
      begin
        if (if_valid_i)
          state_d = DECODE;
      end

      // nop into ex, hold front end
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      FLUSH_WB:
      begin
        if (!fetch_enable_i)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          if (wb_valid_i)
            state_d = SLEEP;
        end
        else
        begin
          // fetch enabled again, release the front end
          if (id_valid_i)
            state_d = DECODE;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= RESET;
    else
      state_q <= state_d;
  end

endmodule

// File: hazard/operand_hazard_unit.sv
// purely combinational, rs3 is always taken from the r4 view whether or not the op is r4-type
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module operand_hazard_unit
  import ctrl_pkg::*;
  import operand_pkg::*;
(
  input  insn_u      instr_i,
  input  logic       rega_used_i,
  input  logic       regb_used_i,
  input  logic       regc_used_i,
  input  jump_kind_e jump_in_dec_i,
  input  logic       data_req_ex_i,
  input  wr_port_t   wr_ex_i,
  input  wr_port_t   wr_wb_i,
  input  wr_port_t   wr_alu_i,
  output fwd_sel_t   fwd_sel_o,
  output logic       load_stall_o,
  output logic       jr_stall_o
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rs3;

  // ex port hits
  logic ex_a, ex_b, ex_c;
  // wb port hits
  logic wb_a, wb_b, wb_c;
  // alu forwarding port hits
  logic alu_a, alu_b, alu_c;

  // a write port hits a source only when enabled and the source is read
  function automatic logic port_hit(
    input wr_port_t               port,
    input logic [`REG_ADDR_W-1:0] raddr,
    input logic                   used
  );
    return port.we && used && (port.waddr == raddr);
  endfunction

  // alu result beats wb result beats register file
  function automatic fwd_sel_e pick_src(input logic alu_hit, input logic wb_hit);
    if (alu_hit)
      return SEL_FW_EX;
    else if (wb_hit)
      return SEL_FW_WB;
    else
      return SEL_REGFILE;
  endfunction

  //////////////////////////////////////////////////
  // source register matching
  //////////////////////////////////////////////////

  assign rs1 = instr_i.r.rs1;
  assign rs2 = instr_i.r.rs2;
  // third source only in the fused layout
  assign rs3 = instr_i.r4.rs3;

  assign ex_a  = port_hit(wr_ex_i, rs1, rega_used_i);
  assign ex_b  = port_hit(wr_ex_i, rs2, regb_used_i);
  assign ex_c  = port_hit(wr_ex_i, rs3, regc_used_i);
  assign wb_a  = port_hit(wr_wb_i, rs1, rega_used_i);
  assign wb_b  = port_hit(wr_wb_i, rs2, regb_used_i);
  assign wb_c  = port_hit(wr_wb_i, rs3, regc_used_i);
  assign alu_a = port_hit(wr_alu_i, rs1, rega_used_i);
  assign alu_b = port_hit(wr_alu_i, rs2, regb_used_i);
  assign alu_c = port_hit(wr_alu_i, rs3, regc_used_i);

  //////////////////////////////////////////////////
  // stalls
  //////////////////////////////////////////////////

  // load data is not ready until wb, so any consumer waits a cycle
  assign load_stall_o = data_req_ex_i && (ex_a || ex_b || ex_c);

  // jalr target comes from rs1 in decode, no forwarding into the pc path
  assign jr_stall_o = (jump_in_dec_i == JALR) && (ex_a || wb_a || alu_a);

  //////////////////////////////////////////////////
  // forwarding selects
  //////////////////////////////////////////////////

  always_comb
  begin
    fwd_sel_o.a = pick_src(alu_a, wb_a);
    fwd_sel_o.b = pick_src(alu_b, wb_b);
    fwd_sel_o.c = pick_src(alu_c, wb_c);

    // x0 reads as zero from the register file
    if (rs1 == '0)
      fwd_sel_o.a = SEL_REGFILE;
    if (rs2 == '0)
      fwd_sel_o.b = SEL_REGFILE;
  end

endmodule

// File: src/redirect_merge.sv
// combinational only, pc_mux_sel reads PC_BOOT whenever no redirect is requested
`timescale 1ns/100ps

module redirect_merge
  import ctrl_pkg::*;
(
  input  redirect_req_t redirect_i,
  input  logic          is_decoding_i,
  input  logic          illegal_insn_i,
  input  logic          load_stall_i,
  input  logic          jr_stall_i,
  output logic          pc_set_o,
  output pc_sel_e       pc_mux_sel_o,
  output logic          deassert_we_o
);

  // jump target depends on a register still in flight
  logic jump_held;
  // any reason the decode instruction must not commit
  logic kill_we;

  //////////////////////////////////////////////////
  // pc redirect
  //////////////////////////////////////////////////

  assign jump_held = redirect_i.jump_only && jr_stall_i;

  // select stays visible while a held jump waits,
  // only the set strobe is withheld
  assign pc_set_o = redirect_i.valid && !jump_held;

  always_comb
  begin
    if (redirect_i.valid)
      pc_mux_sel_o = redirect_i.pc_sel;
    else
      pc_mux_sel_o = PC_BOOT;
  end

  //////////////////////////////////////////////////
  // write enable suppression
  //////////////////////////////////////////////////

  // outside decode nothing valid sits in id
  // stalls replay the same instruction next cycle
  assign kill_we = !is_decoding_i
                || illegal_insn_i
                || load_stall_i
                || jr_stall_i;

  assign deassert_we_o = kill_we;

endmodule

// File: src/riscv_controller.sv
// controller top, wiring only, every output is combinational from state and current inputs
`timescale 1ns/100ps

module riscv_controller
  import ctrl_pkg::*;
  import operand_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // control inputs
  input  logic       fetch_enable_i,
  input  logic       exc_req_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       illegal_insn_i,
  input  jump_kind_e jump_in_ex_i,
  input  jump_kind_e jump_in_dec_i,
  input  logic       branch_decision_i,
  // operand side
  input  logic       rega_used_i,
  input  logic       regb_used_i,
  input  logic       regc_used_i,
  input  insn_u      instr_rdata_i,
  input  logic       data_req_ex_i,
  input  wr_port_t   wr_ex_i,
  input  wr_port_t   wr_wb_i,
  input  wr_port_t   wr_alu_i,
  // stage valids
  input  logic       if_valid_i,
  input  logic       id_valid_i,
  input  logic       ex_valid_i,
  input  logic       wb_valid_i,
  // outputs
  output logic       instr_req_o,
  output logic       core_busy_o,
  output logic       is_decoding_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       exc_ack_o,
  output logic       save_pc_if_o,
  output logic       save_pc_id_o,
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_sel_o,
  output logic       deassert_we_o,
  output fwd_sel_t   fwd_sel_o,
  output logic       load_stall_o,
  output logic       jr_stall_o
);

  // fsm request before the jr stall hold
  redirect_req_t redirect_req;

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .exc_req_i         (exc_req_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .jump_in_ex_i      (jump_in_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .branch_decision_i (branch_decision_i),
    .if_valid_i        (if_valid_i),
    .id_valid_i        (id_valid_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .redirect_o        (redirect_req),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .core_busy_o       (core_busy_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .exc_ack_o         (exc_ack_o),
    .save_pc_if_o      (save_pc_if_o),
    .save_pc_id_o      (save_pc_id_o)
  );

  operand_hazard_unit u_operand_hazard_unit (
    .instr_i       (instr_rdata_i),
    .rega_used_i   (rega_used_i),
    .regb_used_i   (regb_used_i),
    .regc_used_i   (regc_used_i),
    .jump_in_dec_i (jump_in_dec_i),
    .data_req_ex_i (data_req_ex_i),
    .wr_ex_i       (wr_ex_i),
    .wr_wb_i       (wr_wb_i),
    .wr_alu_i      (wr_alu_i),
    .fwd_sel_o     (fwd_sel_o),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o)
  );

  redirect_merge u_redirect_merge (
    .redirect_i     (redirect_req),
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .load_stall_i   (load_stall_o),
    .jr_stall_i     (jr_stall_o),
    .pc_set_o       (pc_set_o),
    .pc_mux_sel_o   (pc_mux_sel_o),
    .deassert_we_o  (deassert_we_o)
  );

endmodule

// File: testbench/controller_properties.sv
// bound into the controller top, state comes in through the bind connection, failures are counted
`timescale 1ns/100ps

module controller_properties
  import ctrl_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input ctrl_state_e state_i,
  input logic        pc_set_i,
  input pc_sel_e     pc_mux_sel_i,
  input logic        branch_decision_i,
  input logic        exc_ack_i
);

  // read by the testbench at the end of the run
  int fail_count = 0;

  //////////////////////////////////////////////////
  // redirect sanity
  //////////////////////////////////////////////////

  // boot redirect is issued from BOOT_SET, never straight out of reset
  pc_set_outside_reset: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> (state_i != RESET))
  else
  begin
    fail_count++;
    $error("pc_set raised while the controller is in RESET");
  end

  // branch target only chosen on a resolved decision
  branch_decision_known: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_mux_sel_i == PC_BRANCH) |-> !$isunknown(branch_decision_i))
  else
  begin
    fail_count++;
    $error("branch select with an unknown branch decision");
  end

  // an acknowledged exception always redirects fetch
  exc_ack_redirects: assert property (@(posedge clk) disable iff (!rst_n)
    exc_ack_i |-> pc_set_i)
  else
  begin
    fail_count++;
    $error("exception acknowledged without pc_set");
  end

endmodule

bind riscv_controller controller_properties u_props (
  .clk               (clk),
  .rst_n             (rst_n),
  .state_i           (u_ctrl_fsm.state_q),
  .pc_set_i          (pc_set_o),
  .pc_mux_sel_i      (pc_mux_sel_o),
  .branch_decision_i (branch_decision_i),
  .exc_ack_i         (exc_ack_o)
);

// File: testbench/tb_controller.sv
// one table row per clock, each row's expected outputs assume the fsm path set up by earlier rows
`timescale 1ns/100ps

module tb_controller
  import ctrl_pkg::*;
  import operand_pkg::*;
;

  // signal names match the dut ports so the instance can use .*
  logic       clk;
  logic       rst_n;
  logic       fetch_enable_i, exc_req_i, eret_insn_i, pipe_flush_i, illegal_insn_i;
  jump_kind_e jump_in_ex_i, jump_in_dec_i;
  logic       branch_decision_i, rega_used_i, regb_used_i, regc_used_i, data_req_ex_i;
  insn_u      instr_rdata_i;
  wr_port_t   wr_ex_i, wr_wb_i, wr_alu_i;
  logic       if_valid_i, id_valid_i, ex_valid_i, wb_valid_i;
  logic       instr_req_o, core_busy_o, is_decoding_o, halt_if_o, halt_id_o, exc_ack_o;
  logic       save_pc_if_o, save_pc_id_o, pc_set_o, deassert_we_o, load_stall_o, jr_stall_o;
  pc_sel_e    pc_mux_sel_o;
  fwd_sel_t   fwd_sel_o;

  // ctl holds fetch_en exc eret flush illegal | branch_dec | if id ex wb valid
  // ops holds used a b c, load in ex, randomize the fields hazard logic never reads
  // st holds req busy decoding halt_if halt_id exc_ack save_if save_id pc_set
  // hz holds deassert_we load_stall jr_stall
  // fwd holds a b c selects, 00 regfile 01 ex 10 wb
  typedef struct packed {
    logic [9:0]  ctl;
    jump_kind_e  jex;
    jump_kind_e  jdec;
    logic [4:0]  ops;
    logic [31:0] insn;
    logic [5:0]  ex;
    logic [5:0]  wb;
    logic [5:0]  alu;
    logic [8:0]  st;
    pc_sel_e     sel;
    logic [2:0]  hz;
    logic [5:0]  fwd;
  } row_t;

  row_t   table_q[$];
  integer seed = 23939;
  int     cycles = 0;
  int     cycle_limit = 1000;

  riscv_controller dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // rs3 at 31..27, rs2 at 24..20, rs1 at 19..15, everything else zero
  function automatic logic [31:0] encode_insn(input logic [4:0] rs3, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
    return {rs3, 2'b00, rs2, rs1, 15'h0000};
  endfunction

  // write port as {address, enable}
  function automatic logic [5:0] encode_port(input logic [4:0] addr, input logic we);
    return {addr, we};
  endfunction

  task automatic add_row(input logic [9:0] ctl, input jump_kind_e jex, input jump_kind_e jdec,
                         input logic [4:0] ops, input logic [31:0] insn, input logic [5:0] ex,
                         input logic [5:0] wb, input logic [5:0] alu, input logic [8:0] st,
                         input pc_sel_e sel, input logic [2:0] hz, input logic [5:0] fwd);
    table_q.push_back('{ctl, jex, jdec, ops, insn, ex, wb, alu, st, sel, hz, fwd});
  endtask

  task automatic build_table();
    // fetch_enable low keeps the core idle
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b000_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b000_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b10000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b000_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    // boot address strobe, then first fetch waits for id_valid
    add_row(10'b10000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_001, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b10000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b10000_0_0100, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b10000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b111_000_000, PC_BOOT, 3'b000, 6'b00_00_00);
    // illegal instruction in decode kills the write
    add_row(10'b10001_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b111_000_000, PC_BOOT, 3'b100, 6'b00_00_00);

    //////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////

    // alu and wb both hold x5, alu wins
    add_row(10'b10000_0_0000, NONE, NONE, 5'b110_0_1, encode_insn(5'd0, 5'd6, 5'd5),
            6'h00, encode_port(5'd5, 1'b1), encode_port(5'd5, 1'b1),
            9'b111_000_000, PC_BOOT, 3'b000, 6'b01_00_00);
    // only wb holds x6
    add_row(10'b10000_0_0000, NONE, NONE, 5'b110_0_1, encode_insn(5'd0, 5'd6, 5'd5),
            6'h00, encode_port(5'd6, 1'b1), encode_port(5'd9, 1'b1),
            9'b111_000_000, PC_BOOT, 3'b000, 6'b00_10_00);
    // x0 on a and b never forwards
    add_row(10'b10000_0_0000, NONE, NONE, 5'b110_0_1, encode_insn(5'd0, 5'd0, 5'd0),
            6'h00, encode_port(5'd0, 1'b1), encode_port(5'd0, 1'b1),
            9'b111_000_000, PC_BOOT, 3'b000, 6'b00_00_00);
    // rs3 = x7 from the r4 view
    add_row(10'b10000_0_0000, NONE, NONE, 5'b001_0_1, encode_insn(5'd7, 5'd4, 5'd3),
            6'h00, 6'h00, encode_port(5'd7, 1'b1),
            9'b111_000_000, PC_BOOT, 3'b000, 6'b00_00_01);

    //////////////////////////////////////////////////
    // stalls
    //////////////////////////////////////////////////

    // load in ex writes x5
    add_row(10'b10000_0_0000, NONE, NONE, 5'b100_1_0, encode_insn(5'd0, 5'd0, 5'd5),
            encode_port(5'd5, 1'b1), 6'h00, 6'h00,
            9'b111_000_000, PC_BOOT, 3'b110, 6'b00_00_00);
    // jalr waits on x5 in wb, strobe held back
    add_row(10'b10000_0_0000, NONE, JALR, 5'b100_0_0, encode_insn(5'd0, 5'd0, 5'd5),
            6'h00, encode_port(5'd5, 1'b1), 6'h00,
            9'b111_000_000, PC_JUMP, 3'b101, 6'b10_00_00);
    add_row(10'b10000_0_0000, NONE, JALR, 5'b100_0_0, encode_insn(5'd0, 5'd0, 5'd5),
            6'h00, encode_port(5'd5, 1'b0), 6'h00,
            9'b111_000_001, PC_JUMP, 3'b000, 6'b00_00_00);

    // taken branch with if_valid low, then wait in branch delay
    add_row(10'b10000_1_0000, COND, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_001, PC_BRANCH, 3'b100, 6'b00_00_00);
    add_row(10'b10000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b10000_0_1000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_000, PC_BOOT, 3'b100, 6'b00_00_00);

    // exception over a jal saves the if pc, otherwise the id pc
    add_row(10'b11000_0_0000, NONE, JAL, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b111_001_101, PC_EXCEPTION, 3'b000, 6'b00_00_00);
    add_row(10'b11000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b111_001_011, PC_EXCEPTION, 3'b000, 6'b00_00_00);
    // eret beats both exception and jump
    add_row(10'b11100_0_0000, NONE, JAL, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b111_001_101, PC_ERET, 3'b000, 6'b00_00_00);

    //////////////////////////////////////////////////
    // flush and sleep
    //////////////////////////////////////////////////

    add_row(10'b00010_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b111_110_000, PC_BOOT, 3'b000, 6'b00_00_00);
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_110_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b00000_0_0010, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_110_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_110_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b00000_0_0001, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_110_000, PC_BOOT, 3'b100, 6'b00_00_00);
    // asleep, then an exception wakes it into first fetch
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b000_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b000_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b01000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b000_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
    add_row(10'b00000_0_0000, NONE, NONE, 5'b000_0_0, 32'h0, 6'h00, 6'h00, 6'h00,
            9'b110_000_000, PC_BOOT, 3'b100, 6'b00_00_00);
  endtask

  task automatic drive_row(input row_t r);
    logic [31:0] word;
    word = r.insn;
    // rd, funct3 and opcode only
    if (r.ops[0])
      word[14:0] = 15'($random(seed));
    {fetch_enable_i, exc_req_i, eret_insn_i, pipe_flush_i, illegal_insn_i,
     branch_decision_i, if_valid_i, id_valid_i, ex_valid_i, wb_valid_i} = r.ctl;
    jump_in_ex_i  = r.jex;
    jump_in_dec_i = r.jdec;
    {rega_used_i, regb_used_i, regc_used_i, data_req_ex_i} = r.ops[4:1];
    instr_rdata_i = word;
    wr_ex_i       = r.ex;
    wr_wb_i       = r.wb;
    wr_alu_i      = r.alu;
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_row(input int idx, input row_t r);
    logic [8:0] st;
    logic [2:0] hz;
    logic [5:0] fwd;
    st  = {instr_req_o, core_busy_o, is_decoding_o, halt_if_o, halt_id_o, exc_ack_o,
           save_pc_if_o, save_pc_id_o, pc_set_o};
    hz  = {deassert_we_o, load_stall_o, jr_stall_o};
    fwd = fwd_sel_o;
    compare_value(32'(st), 32'(r.st), $sformatf("row %0d status flags", idx));
    compare_value(32'(pc_mux_sel_o), 32'(r.sel), $sformatf("row %0d pc select", idx));
    compare_value(32'(hz), 32'(r.hz), $sformatf("row %0d write enable and stalls", idx));
    compare_value(32'(fwd), 32'(r.fwd), $sformatf("row %0d forwarding selects", idx));
  endtask

  // run limit from the table length
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish after %0d clock cycles", cycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  initial
  begin
    rst_n = 1'b0;
    drive_row('0);
    build_table();
    cycle_limit = table_q.size() + 50;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    // drive 1 ns after the edge, sample 1 ns before the next
    foreach (table_q[i])
    begin
      @(posedge clk);
      #1 drive_row(table_q[i]);
      #8 check_row(i, table_q[i]);
    end

    // let the bound assertions see the last row
    @(posedge clk);
    #1;
    if (dut.u_props.fail_count == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

// File: build.f
+incdir+common
common/ctrl_pkg.sv
common/operand_pkg.sv
ctrl/ctrl_fsm.sv
hazard/operand_hazard_unit.sv
src/redirect_merge.sv
src/riscv_controller.sv
testbench/controller_properties.sv
testbench/tb_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the controller testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_controller -Mdir obj_dir -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/Vtb_controller +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
